// ==== Bender.yml ====
package:
  name: board_ctrl

sources:
  - files:
      - logic/board_pkg.sv
      - logic/board_keys_if.sv
      - logic/reset_sequencer.sv
      - logic/input_merge.sv
      - logic/control_toggles.sv
      - logic/board_ctrl_top.sv
  - target: test
    files:
      - verif/board_ctrl_checker.sv
      - verif/board_ctrl_tb.sv

// ==== logic/board_ctrl_top.sv ====
// Arcade board control block
// Reset sequencing, player input merging and live pause and layer toggles

`default_nettype none

module board_ctrl_top import board_pkg::*; #(
    parameter int unsigned RST_CNT_W         = 8,
    parameter int unsigned THREE_BUTTONS     = 0,
    parameter bit          INPUTS_ACTIVE_LOW = 1'b1
) (
    input  wire          clk_sys,
    input  wire          game_rst,
    input  wire          rst_req,
    input  wire          dip_flip,   // A change restarts the game reset
    input  wire          rot_control,
    input  wire          board_joy_t   board_joystick1,
    input  wire          board_joy_t   board_joystick2,
    input  wire          game_joy_t    key_joy1,
    input  wire          game_joy_t    key_joy2,
    input  wire          player_pair_t key_start,
    input  wire          player_pair_t key_coin,
    input  wire          key_service,
    input  wire          key_pause,
    input  wire          key_reset,
    input  wire          gfx_mask_t    key_gfx,
    output logic         core_rst,
    output logic         play_rst,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         game_service,
    output logic         game_pause,
    output gfx_mask_t    gfx_en
);

    logic soft_rst_req;

    board_keys_if keys_if ();

    reset_sequencer #(
        .RST_CNT_W    (RST_CNT_W)
    ) u_reset_sequencer (
        .clk_sys      (clk_sys),
        .game_rst     (game_rst),
        .rst_req      (rst_req),
        .dip_flip     (dip_flip),
        .soft_rst_req (soft_rst_req),
        .core_rst     (core_rst),
        .play_rst     (play_rst)
    );

    input_merge #(
        .THREE_BUTTONS     (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW (INPUTS_ACTIVE_LOW)
    ) u_input_merge (
        .clk_sys         (clk_sys),
        .core_rst        (core_rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_service     (key_service),
        .key_pause       (key_pause),
        .key_reset       (key_reset),
        .key_gfx         (key_gfx),
        .rot_control     (rot_control),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .keys            (keys_if.sampler)
    );

    control_toggles u_control_toggles (
        .clk_sys      (clk_sys),
        .keys         (keys_if.keeper),
        .game_pause   (game_pause),
        .gfx_en       (gfx_en),
        .soft_rst_req (soft_rst_req) // Back to the sequencer
    );

endmodule

`default_nettype wire

// ==== logic/board_keys_if.sv ====
// Toggle sources from the input sampler to the toggle logic
// All signals are levels refreshed every cycle, no handshake

`default_nettype none

interface board_keys_if import board_pkg::*; ();

    logic      key_pause;   // Registered keyboard pause
    logic      key_reset;   // Registered keyboard reset
    gfx_mask_t key_gfx;     // Registered layer keys
    logic      joy_pause;   // Pause button of either joystick
    logic      core_rst;
    logic      rot_control; // Registered rotation setting

    modport sampler (
        output key_pause, key_reset, key_gfx, joy_pause, core_rst, rot_control
    );

    modport keeper (
        input key_pause, key_reset, key_gfx, joy_pause, core_rst, rot_control
    );

endinterface

`default_nettype wire

// ==== logic/board_pkg.sv ====
// Board control package
// Vector types for joystick, player and graphics words, the reset
// sequencer states and the base bit positions in the board joystick word

`default_nettype none

package board_pkg;

    // Raw joystick word as delivered by the board
    typedef logic [15:0] board_joy_t;

    // Game side joystick, directions in bits 3..0, buttons above
    typedef logic [9:0] game_joy_t;

    typedef logic [1:0] player_pair_t; // One bit per player
    typedef logic [3:0] gfx_mask_t;    // Graphics layer enables

    typedef enum logic [1:0] {
        RST_POWER, // Power-on count, both resets held
        RST_GAME,  // Game reset stretch
        RST_RUN    // Both resets released
    } rst_state_t;

    // Base positions in the board joystick word
    // shifted up by one on three-button boards
    localparam int unsigned BASE_START1_BIT = 6;
    localparam int unsigned BASE_START2_BIT = 7;
    localparam int unsigned BASE_COIN_BIT   = 8;
    localparam int unsigned BASE_PAUSE_BIT  = 9;

endpackage

`default_nettype wire

// ==== logic/control_toggles.sv ====
// Live toggles
// Rising edges flip the pause flag and the graphics layer enables,
// and the reset key gives a single-cycle soft reset request

`default_nettype none

module control_toggles import board_pkg::*; (
    input  wire         clk_sys,
    board_keys_if.keeper keys,
    output logic        game_pause,
    output gfx_mask_t   gfx_en,
    output logic        soft_rst_req
);

    logic      last_key_pause;
    logic      last_joy_pause;
    logic      last_key_reset;
    gfx_mask_t last_key_gfx;
    logic      pause_rise;
    logic      reset_rise;
    gfx_mask_t gfx_rise;

    // Previous levels, tracked through reset so a held key
    // gives no edge once reset is released
    always_ff @(posedge clk_sys) begin
        last_key_pause <= keys.key_pause;
        last_joy_pause <= keys.joy_pause;
        last_key_reset <= keys.key_reset;
        last_key_gfx   <= keys.key_gfx;
    end

    assign pause_rise = (keys.key_pause & ~last_key_pause) |
                        (keys.joy_pause & ~last_joy_pause);
    assign reset_rise = keys.key_reset & ~last_key_reset;
    assign gfx_rise   = keys.key_gfx & ~last_key_gfx;

    always_ff @(posedge clk_sys) begin
        if (keys.core_rst) begin
            game_pause   <= 1'b0;
            gfx_en       <= '1; // All layers on
            soft_rst_req <= 1'b0;
        end else begin
            if (pause_rise) begin
                game_pause <= ~game_pause;
            end
            gfx_en       <= gfx_en ^ gfx_rise; // Flip only the pressed layers
            soft_rst_req <= reset_rise;
        end
    end

endmodule

`default_nettype wire

// ==== logic/input_merge.sv ====
// Player input sampler
// Synchronises board joysticks and decoded keys, merges them into the
// game joystick, coin, start and service signals, rotates the directions
// for vertical screens and sets the output polarity

`default_nettype none

module input_merge import board_pkg::*; #(
    parameter int unsigned THREE_BUTTONS     = 0,
    parameter bit          INPUTS_ACTIVE_LOW = 1'b1
) (
    input  wire          clk_sys,
    input  wire          core_rst,
    input  wire          board_joy_t   board_joystick1,
    input  wire          board_joy_t   board_joystick2,
    input  wire          game_joy_t    key_joy1,
    input  wire          game_joy_t    key_joy2,
    input  wire          player_pair_t key_start,
    input  wire          player_pair_t key_coin,
    input  wire          key_service,
    input  wire          key_pause,
    input  wire          key_reset,
    input  wire          gfx_mask_t    key_gfx,
    input  wire          rot_control,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         game_service,
    board_keys_if.sampler keys
);

    localparam int unsigned START1_BIT = BASE_START1_BIT + THREE_BUTTONS;
    localparam int unsigned START2_BIT = BASE_START2_BIT + THREE_BUTTONS;
    localparam int unsigned COIN_BIT   = BASE_COIN_BIT + THREE_BUTTONS;
    localparam int unsigned PAUSE_BIT  = BASE_PAUSE_BIT + THREE_BUTTONS;

    localparam game_joy_t    JOY_INV  = {10{INPUTS_ACTIVE_LOW}};
    localparam player_pair_t PAIR_INV = {2{INPUTS_ACTIVE_LOW}};

    board_joy_t   joy1_q, joy2_q;
    game_joy_t    key_joy1_q, key_joy2_q;
    player_pair_t key_start_q, key_coin_q;
    logic         key_service_q;

    // Vertical screens swap the axes; buttons stay put
    function automatic game_joy_t apply_rotation(input game_joy_t joy, input logic rot);
        game_joy_t rotated;
        rotated = {joy[9:4], joy[0], joy[1], joy[3], joy[2]};
        return rot ? rotated : joy;
    endfunction

    // Sync stage
    always_ff @(posedge clk_sys) begin
        joy1_q           <= board_joystick1;
        joy2_q           <= board_joystick2;
        key_joy1_q       <= key_joy1;
        key_joy2_q       <= key_joy2;
        key_start_q      <= key_start;
        key_coin_q       <= key_coin;
        key_service_q    <= key_service;
        keys.key_pause   <= key_pause;
        keys.key_reset   <= key_reset;
        keys.key_gfx     <= key_gfx;
        keys.rot_control <= rot_control;
    end

    assign keys.joy_pause = joy1_q[PAUSE_BIT] | joy2_q[PAUSE_BIT];
    assign keys.core_rst  = core_rst;

    // Output stage
    always_ff @(posedge clk_sys) begin
        game_joystick1 <= JOY_INV ^ apply_rotation(joy1_q[9:0] | key_joy1_q,
                                                   keys.rot_control);
        game_joystick2 <= JOY_INV ^ apply_rotation(joy2_q[9:0] | key_joy2_q,
                                                   keys.rot_control);

        game_coin  <= PAIR_INV ^ ({joy2_q[COIN_BIT], joy1_q[COIN_BIT]} | key_coin_q);
        game_start <= PAIR_INV ^ ({joy1_q[START2_BIT], joy1_q[START1_BIT]} |
                                  {joy2_q[START2_BIT], joy2_q[START1_BIT]} |
                                  key_start_q);
    end

    always_ff @(posedge clk_sys) begin
        if (core_rst) begin
            game_service <= INPUTS_ACTIVE_LOW; // Inactive level
        end else begin
            game_service <= key_service_q ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reset_sequencer.sv ====
// Reset sequencer
// Power-on counter for the system reset, then a stretched game reset
// that restarts on an external request, a soft reset key or a flip change

`default_nettype none

module reset_sequencer import board_pkg::*; #(
    parameter int unsigned RST_CNT_W = 8
) (
    input  wire  clk_sys,
    input  wire  game_rst,
    input  wire  rst_req,      // External reset request
    input  wire  dip_flip,
    input  wire  soft_rst_req, // One-cycle pulse from the reset key
    output logic core_rst,
    output logic play_rst
);

    rst_state_t           state;
    logic [RST_CNT_W-1:0] power_cnt;
    logic [RST_CNT_W-1:0] game_cnt;
    logic                 last_flip;
    logic                 flip_change;
    logic                 game_req;

    // Flip changes are spotted against last cycle's setting
    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
    end

    assign flip_change = dip_flip != last_flip;
    assign game_req    = rst_req | soft_rst_req | flip_change;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            state     <= RST_POWER;
            power_cnt <= '0; // Held at zero while reset is asserted
            game_cnt  <= '0;
        end else begin
            case (state)
                RST_POWER: begin
                    if (power_cnt == '1) begin
                        state    <= RST_GAME;
                        game_cnt <= '0;
                    end else begin
                        power_cnt <= power_cnt + 1'b1;
                    end
                end
                RST_GAME: begin
                    if (game_req) begin
                        game_cnt <= '0; // Restart the stretch
                    end else if (game_cnt == '1) begin
                        state <= RST_RUN;
                    end else begin
                        game_cnt <= game_cnt + 1'b1;
                    end
                end
                RST_RUN: begin
                    if (game_req) begin
                        state    <= RST_GAME;
                        game_cnt <= '0;
                    end
                end
                default: begin
                    state     <= RST_POWER;
                    power_cnt <= '0;
                end
            endcase
        end
    end

    // Game reset always covers the system reset
    assign core_rst = state == RST_POWER;
    assign play_rst = state != RST_RUN;

endmodule

`default_nettype wire

// ==== tb.f ====
logic/board_pkg.sv
logic/board_keys_if.sv
logic/reset_sequencer.sv
logic/input_merge.sv
logic/control_toggles.sv
logic/board_ctrl_top.sv
verif/board_ctrl_checker.sv
verif/board_ctrl_tb.sv

// ==== verif/board_ctrl_checker.sv ====
// Board control checker
// Concurrent assertions on the layer enables, the soft reset pulse and
// the ordering of the two resets, bound into the top level

`default_nettype none

module board_ctrl_checker import board_pkg::*; (
    input wire            clk_sys,
    input wire            game_rst,
    input wire            core_rst,
    input wire            play_rst,
    input wire            soft_rst_req,
    input wire gfx_mask_t key_gfx,
    input wire gfx_mask_t gfx_en
);

    int unsigned fail_cnt = 0; // Read by the testbench at the end

    // A layer bit may flip only two cycles after its key rose
    property gfx_follows_keys;
        @(posedge clk_sys) disable iff (game_rst)
        !$past(core_rst) |->
            ((gfx_en ^ $past(gfx_en)) & ~($past(key_gfx, 2) & ~$past(key_gfx, 3))) == '0;
    endproperty

    property soft_req_single;
        @(posedge clk_sys) disable iff (game_rst)
        soft_rst_req |=> !soft_rst_req;
    endproperty

    // Game reset still held in the cycle after the system reset
    property play_covers_core;
        @(posedge clk_sys) disable iff (game_rst)
        core_rst |-> play_rst ##1 play_rst;
    endproperty

    gfx_change_a: assert property (gfx_follows_keys)
        else begin
            $error("gfx_en changed without a rising edge on its layer key");
            fail_cnt++;
        end

    soft_req_a: assert property (soft_req_single)
        else begin
            $error("soft_rst_req stayed high for two cycles");
            fail_cnt++;
        end

    reset_order_a: assert property (play_covers_core)
        else begin
            $error("play_rst low while or just after core_rst high");
            fail_cnt++;
        end

endmodule

bind board_ctrl_top board_ctrl_checker u_checker (
    .clk_sys      (clk_sys),
    .game_rst     (game_rst),
    .core_rst     (core_rst),
    .play_rst     (play_rst),
    .soft_rst_req (soft_rst_req), // Internal wire of the top level
    .key_gfx      (key_gfx),
    .gfx_en       (gfx_en)
);

`default_nettype wire

// ==== verif/board_ctrl_tb.sv ====
// Board control testbench
// Reset release, input merge with rotation, pause and layer toggles
// and the game reset requests, checked with immediate assertions

`default_nettype none

module board_ctrl_tb import board_pkg::*; ();

    localparam int unsigned RST_CNT_W = 4;
    localparam int STRETCH     = 1 << RST_CNT_W;
    localparam int MERGE_LEN   = 40;
    localparam int HOLD_LEN    = 6;
    localparam int RESET_LEN   = 4 + 2 * STRETCH + 4;
    localparam int MERGE_TOTAL = 2 * (MERGE_LEN + 6);
    localparam int TOGGLE_LEN  = 10 * (HOLD_LEN + 8); // Nine toggle runs and a spare
    localparam int REQUEST_LEN = 3 * (2 * STRETCH + 12);
    localparam int WATCHDOG_CYCLES = RESET_LEN + MERGE_TOTAL + TOGGLE_LEN + REQUEST_LEN + 200;

    typedef struct packed {
        board_joy_t   joy1;
        board_joy_t   joy2;
        game_joy_t    kjoy1;
        game_joy_t    kjoy2;
        player_pair_t start;
        player_pair_t coin;
        logic         service;
        logic         rot;
    } merge_vec_t;

    logic         clk_sys = 1'b0;
    logic         game_rst, rst_req, dip_flip, rot_control;
    board_joy_t   board_joystick1, board_joystick2;
    game_joy_t    key_joy1, key_joy2;
    player_pair_t key_start, key_coin;
    logic         key_service, key_pause, key_reset;
    gfx_mask_t    key_gfx;
    logic         core_rst, play_rst, game_service, game_pause;
    game_joy_t    game_joystick1, game_joystick2;
    player_pair_t game_coin, game_start;
    gfx_mask_t    gfx_en;

    merge_vec_t history [3]; // Newest vector at index 0
    string      test_name;
    int         errors, errors_at_start, tests_passed, tests_failed, cycles, checker_fails;

    board_ctrl_top #(
        .RST_CNT_W         (RST_CNT_W),
        .THREE_BUTTONS     (0),
        .INPUTS_ACTIVE_LOW (1'b1)
    ) dut (.*);

    always #4 clk_sys = ~clk_sys;

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s done, no errors", test_name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected)
        else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_window(input string what, input int lo, input int hi, input int actual);
        assert (actual >= lo && actual <= hi)
        else begin
            $display("FAIL %s %s: expected %0d to %0d cycles, actual %0d",
                     test_name, what, lo, hi, actual);
            errors++;
        end
    endtask

    // Game word for one player, active low, directions rotated on request
    function automatic game_joy_t expected_joy(input board_joy_t board, input game_joy_t keys,
                                               input logic rot);
        game_joy_t merged;
        game_joy_t result;
        merged = board[9:0] | keys;
        result = merged;
        if (rot) begin
            result[3] = merged[0];
            result[2] = merged[1];
            result[1] = merged[3];
            result[0] = merged[2];
        end
        return ~result;
    endfunction

    task automatic run_merge(input logic rot, input int count);
        merge_vec_t   v;
        merge_vec_t   old;
        player_pair_t exp_start;
        player_pair_t exp_coin;
        for (int i = 0; i < count; i++) begin
            @(posedge clk_sys);
            v.joy1    = board_joy_t'($urandom);
            v.joy2    = board_joy_t'($urandom);
            v.kjoy1   = game_joy_t'($urandom);
            v.kjoy2   = game_joy_t'($urandom);
            v.start   = player_pair_t'($urandom);
            v.coin    = player_pair_t'($urandom);
            v.service = 1'($urandom);
            v.rot     = rot;
            board_joystick1 <= v.joy1;
            board_joystick2 <= v.joy2;
            key_joy1        <= v.kjoy1;
            key_joy2        <= v.kjoy2;
            key_start       <= v.start;
            key_coin        <= v.coin;
            key_service     <= v.service;
            rot_control     <= v.rot;
            history[2] = history[1];
            history[1] = history[0];
            history[0] = v;
            @(negedge clk_sys);
            if (i >= 2) begin // Outputs now reflect the vector of two edges back
                old = history[2];
                exp_start[0] = ~(old.joy1[BASE_START1_BIT] | old.joy2[BASE_START1_BIT] |
                                 old.start[0]);
                exp_start[1] = ~(old.joy1[BASE_START2_BIT] | old.joy2[BASE_START2_BIT] |
                                 old.start[1]);
                exp_coin = ~({old.joy2[BASE_COIN_BIT], old.joy1[BASE_COIN_BIT]} | old.coin);
                check_value("game_joystick1", expected_joy(old.joy1, old.kjoy1, old.rot),
                            game_joystick1);
                check_value("game_joystick2", expected_joy(old.joy2, old.kjoy2, old.rot),
                            game_joystick2);
                check_value("game_coin", exp_coin, game_coin);
                check_value("game_start", exp_start, game_start);
                check_value("game_service", !old.service, game_service);
            end
        end
    endtask

    task automatic clear_inputs();
        @(posedge clk_sys);
        {board_joystick1, board_joystick2, key_joy1, key_joy2} <= '0;
        {key_start, key_coin, key_service, key_pause, key_reset, key_gfx} <= '0;
        rst_req     <= 1'b0;
        rot_control <= 1'b0;
        repeat (4) @(negedge clk_sys);
    endtask

    // 0 key pause, 1 and 2 joystick pause bits, 3 and up the layer keys
    task automatic set_source(input int src, input logic level);
        case (src)
            0: key_pause <= level;
            1: board_joystick1[BASE_PAUSE_BIT] <= level;
            2: board_joystick2[BASE_PAUSE_BIT] <= level;
            default: key_gfx[src - 3] <= level;
        endcase
    endtask

    // Starts and ends on a falling edge
    task automatic toggle_source(input int src, input int hold);
        logic      exp_pause;
        gfx_mask_t exp_gfx;
        exp_pause = game_pause;
        exp_gfx   = gfx_en;
        @(posedge clk_sys);
        set_source(src, 1'b1);
        @(posedge clk_sys);
        if (hold == 0) set_source(src, 1'b0);
        @(negedge clk_sys);
        check_value("game_pause before flip", exp_pause, game_pause);
        check_value("gfx_en before flip", exp_gfx, gfx_en);
        if (src < 3) exp_pause = ~exp_pause;
        else exp_gfx[src - 3] = ~exp_gfx[src - 3];
        @(negedge clk_sys);
        check_value("game_pause", exp_pause, game_pause);
        check_value("gfx_en", exp_gfx, gfx_en);
        if (hold > 0) begin
            repeat (hold) @(negedge clk_sys);
            check_value("game_pause held", exp_pause, game_pause);
            @(posedge clk_sys);
            set_source(src, 1'b0);
        end
        repeat (3) @(negedge clk_sys);
        check_value("game_pause after release", exp_pause, game_pause);
        check_value("gfx_en after release", exp_gfx, gfx_en);
    endtask

    // 0 reset key, 1 external request, 2 flip change
    task automatic run_request(input int src);
        int rise;
        int width;
        @(posedge clk_sys);
        case (src)
            0: key_reset <= 1'b1;
            1: rst_req <= 1'b1;
            default: dip_flip <= ~dip_flip;
        endcase
        // Reset key held over several cycles, still a single request
        repeat ((src == 0) ? 3 : 1) @(posedge clk_sys);
        key_reset <= 1'b0;
        rst_req   <= 1'b0;
        rise = 0;
        do begin
            @(negedge clk_sys);
            rise++;
        end while (play_rst !== 1'b1 && rise < 10);
        check_window("play_rst rise", 1, 4, rise);
        width = 0;
        while (play_rst === 1'b1 && width < 4 * STRETCH) begin
            check_value("core_rst during request", 1'b0, core_rst);
            @(negedge clk_sys);
            width++;
        end
        check_window("play_rst width", STRETCH - 2, STRETCH + 2, width);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h7964a4bc));
        game_rst = 1'b1;
        {rst_req, dip_flip, rot_control} = '0;
        {board_joystick1, board_joystick2, key_joy1, key_joy2} = '0;
        {key_start, key_coin, key_service, key_pause, key_reset, key_gfx} = '0;

        start_test("reset_release");
        repeat (4) @(posedge clk_sys);
        game_rst <= 1'b0;
        @(negedge clk_sys);
        cycles = 0;
        while (core_rst === 1'b1 && cycles < 4 * STRETCH) begin
            @(negedge clk_sys);
            cycles++;
        end
        check_window("core_rst release", STRETCH, STRETCH + 2, cycles);
        cycles = 0;
        while (play_rst === 1'b1 && cycles < 4 * STRETCH) begin
            @(negedge clk_sys);
            cycles++;
        end
        check_window("play_rst release", STRETCH - 2, STRETCH + 2, cycles);
        check_value("game_pause", 1'b0, game_pause);
        check_value("gfx_en", 4'hf, gfx_en);
        check_value("game_service", 1'b1, game_service);
        finish_test();

        start_test("merge_normal");
        run_merge(1'b0, MERGE_LEN);
        clear_inputs();
        finish_test();

        start_test("merge_rotated");
        run_merge(1'b1, MERGE_LEN);
        clear_inputs();
        finish_test();

        start_test("pause_toggle");
        for (int src = 0; src < 3; src++) toggle_source(src, 0);
        toggle_source(0, HOLD_LEN);
        toggle_source(1, HOLD_LEN);
        finish_test();

        start_test("gfx_toggle");
        for (int bit_idx = 0; bit_idx < 4; bit_idx++) toggle_source(3 + bit_idx, 0);
        finish_test();

        start_test("reset_requests");
        for (int src = 0; src < 3; src++) run_request(src);
        finish_test();

        checker_fails = dut.u_checker.fail_cnt;
        $display("Tests passed: %0d, tests failed: %0d, checker failures: %0d",
                 tests_passed, tests_failed, checker_fails);
        if (tests_failed == 0 && checker_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
